// File: Makefile
# Verilator simulation of the tunnel subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_tunnel_subsystem \
		-f tunnel_subsystem_top.f --Mdir obj_dir
	./obj_dir/Vtb_tunnel_subsystem > sim.log 2>&1; cat sim.log
	@! grep -q "Some tests failed" sim.log
	@grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: hw/tunnel_cfg_regs.sv
// tunnel configuration registers
// AXI4-Lite slave holding the controller and HCP MAC addresses and the
// encapsulated, decapsulated and short frame counters
`timescale 1ns/1ns
`default_nettype none

module tunnel_cfg_regs
    import tunnel_pkg::*;
#(
    parameter int CNT_W = 16
) (
    input  wire                   i_clk,
    input  wire                   i_rst_n,

    input  wire  [REG_ADDR_W-1:0] i_axil_awaddr,
    input  wire                   i_axil_awvalid,
    output logic                  o_axil_awready,
    input  wire  [31:0]           i_axil_wdata,
    input  wire  [3:0]            i_axil_wstrb,
    input  wire                   i_axil_wvalid,
    output logic                  o_axil_wready,
    output logic [1:0]            o_axil_bresp,
    output logic                  o_axil_bvalid,
    input  wire                   i_axil_bready,
    input  wire  [REG_ADDR_W-1:0] i_axil_araddr,
    input  wire                   i_axil_arvalid,
    output logic                  o_axil_arready,
    output logic [31:0]           o_axil_rdata,
    output logic [1:0]            o_axil_rresp,
    output logic                  o_axil_rvalid,
    input  wire                   i_axil_rready,

    input  wire                   i_encap_done,
    input  wire                   i_decap_done,
    input  wire                   i_decap_short,
    output logic [47:0]           o_ctrl_mac,
    output logic [47:0]           o_hcp_mac
);

    // byte-masked merge of new write data into a register
    function automatic logic [31:0] merge_strb(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////////////////////
    logic                  aw_held;
    logic                  w_held;
    logic [REG_ADDR_W-1:0] aw_addr_q;
    logic [31:0]           w_data_q;
    logic [3:0]            w_strb_q;

    logic                  aw_hs;
    logic                  w_hs;
    logic                  wr_fire;
    logic [REG_ADDR_W-1:0] wr_addr;
    logic [31:0]           wr_data;
    logic [3:0]            wr_strb;
    logic                  aw_held_nxt;
    logic                  w_held_nxt;
    logic                  bvalid_nxt;

    assign aw_hs   = i_axil_awvalid && o_axil_awready;
    assign w_hs    = i_axil_wvalid && o_axil_wready;
    // write goes ahead once both halves are in hand
    assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
    assign wr_addr = aw_held ? aw_addr_q : i_axil_awaddr;
    assign wr_data = w_held ? w_data_q : i_axil_wdata;
    assign wr_strb = w_held ? w_strb_q : i_axil_wstrb;

    assign aw_held_nxt = !wr_fire && (aw_held || aw_hs);
    assign w_held_nxt  = !wr_fire && (w_held || w_hs);
    assign bvalid_nxt  = wr_fire || (o_axil_bvalid && !i_axil_bready);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            aw_held        <= 1'b0;
            w_held         <= 1'b0;
            o_axil_bvalid  <= 1'b0;
            o_axil_awready <= 1'b0;
            o_axil_wready  <= 1'b0;
        end else begin
            aw_held        <= aw_held_nxt;
            w_held         <= w_held_nxt;
            o_axil_bvalid  <= bvalid_nxt;
            o_axil_awready <= !aw_held_nxt && !bvalid_nxt;
            o_axil_wready  <= !w_held_nxt && !bvalid_nxt;
        end
    end

    // parked address and data
    always_ff @(posedge i_clk) begin
        if (aw_hs) begin
            aw_addr_q <= i_axil_awaddr;
        end
        if (w_hs) begin
            w_data_q <= i_axil_wdata;
            w_strb_q <= i_axil_wstrb;
        end
    end

    // MAC registers; counters and unused offsets ignore writes
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ctrl_mac <= '0;
            o_hcp_mac  <= '0;
        end else if (wr_fire) begin
            case (wr_addr)
                REG_CTRL_MAC_HI:
                    o_ctrl_mac[47:32] <= 16'(merge_strb({16'd0, o_ctrl_mac[47:32]},
                                                        wr_data, wr_strb));
                REG_CTRL_MAC_LO:
                    o_ctrl_mac[31:0] <= merge_strb(o_ctrl_mac[31:0], wr_data, wr_strb);
                REG_HCP_MAC_HI:
                    o_hcp_mac[47:32] <= 16'(merge_strb({16'd0, o_hcp_mac[47:32]},
                                                       wr_data, wr_strb));
                REG_HCP_MAC_LO:
                    o_hcp_mac[31:0] <= merge_strb(o_hcp_mac[31:0], wr_data, wr_strb);
                default: ;
            endcase
        end
    end

    assign o_axil_bresp = RESP_OKAY;

    ////////////////////////////////////////////////////////////////////////////
    // frame counters, wrapping
    ////////////////////////////////////////////////////////////////////////////
    logic [CNT_W-1:0] encap_cnt;
    logic [CNT_W-1:0] decap_cnt;
    logic [CNT_W-1:0] short_cnt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            encap_cnt <= '0;
            decap_cnt <= '0;
            short_cnt <= '0;
        end else begin
            if (i_encap_done)  encap_cnt <= encap_cnt + 1'b1;
            if (i_decap_done)  decap_cnt <= decap_cnt + 1'b1;
            if (i_decap_short) short_cnt <= short_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////////////
    logic        ar_hs;
    logic        rvalid_nxt;
    logic [31:0] rd_mux;

    assign ar_hs      = i_axil_arvalid && o_axil_arready;
    assign rvalid_nxt = ar_hs || (o_axil_rvalid && !i_axil_rready);

    always_comb begin
        case (i_axil_araddr)
            REG_CTRL_MAC_HI: rd_mux = {16'd0, o_ctrl_mac[47:32]};
            REG_CTRL_MAC_LO: rd_mux = o_ctrl_mac[31:0];
            REG_HCP_MAC_HI:  rd_mux = {16'd0, o_hcp_mac[47:32]};
            REG_HCP_MAC_LO:  rd_mux = o_hcp_mac[31:0];
            REG_ENCAP_CNT:   rd_mux = 32'(encap_cnt);
            REG_DECAP_CNT:   rd_mux = 32'(decap_cnt);
            REG_SHORT_CNT:   rd_mux = 32'(short_cnt);
            default:         rd_mux = '0;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_axil_rvalid  <= 1'b0;
            o_axil_arready <= 1'b0;
        end else begin
            o_axil_rvalid  <= rvalid_nxt;
            o_axil_arready <= !rvalid_nxt;
        end
    end

    always_ff @(posedge i_clk) begin
        if (ar_hs) begin
            o_axil_rdata <= rd_mux;
        end
    end

    assign o_axil_rresp = RESP_OKAY;

    // responses stay put until the master takes them
    a_bvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_axil_bvalid && !i_axil_bready |=> o_axil_bvalid);
    a_rvalid_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_axil_rvalid && !i_axil_rready |=> o_axil_rvalid && $stable(o_axil_rdata));

endmodule

`default_nettype wire

// File: hw/tunnel_frame_process.sv
// tunnel frame processor
// prepends the TSMP header to frames bound for the controller and strips
// it from frames coming back, using a 16-word delay line for the replay
`timescale 1ns/1ns
`default_nettype none

module tunnel_frame_process
    import tunnel_pkg::*;
(
    input  wire         i_clk,
    input  wire         i_rst_n,
    input  wire  [47:0] i_ctrl_mac,
    input  wire  [47:0] i_hcp_mac,
    input  wire  [8:0]  i_data,
    input  wire         i_data_wr,
    input  wire         i_encapsulated_flag,
    output logic [8:0]  o_data,
    output logic        o_data_wr,
    output logic        o_encap_done,
    output logic        o_decap_done,
    output logic        o_decap_short
);

    localparam int DLY_W  = 9 * TSMP_HEAD_BYTES;
    localparam int HCNT_W = $clog2(TSMP_HEAD_BYTES);
    localparam logic [HCNT_W-1:0] HCNT_LAST = HCNT_W'(TSMP_HEAD_BYTES - 1);

    localparam logic [2:0] ST_IDLE      = 3'd0;
    localparam logic [2:0] ST_HEAD      = 3'd1;
    localparam logic [2:0] ST_REPLAY    = 3'd2;
    localparam logic [2:0] ST_DISCARD   = 3'd3;
    localparam logic [2:0] ST_DEC_FIRST = 3'd4;
    localparam logic [2:0] ST_PASS      = 3'd5;

    // delay line, oldest word at the top
    logic [DLY_W-1:0] dly_line;
    logic [8:0]       dly_tap;

    always_ff @(posedge i_clk) begin
        dly_line <= {dly_line[DLY_W-10:0], (i_data_wr ? i_data : 9'd0)};
    end

    assign dly_tap = dly_line[DLY_W-1 -: 9];

    // header built from the live MAC values, latched at frame start
    tsmp_head_u head_new;
    tsmp_head_u head_q;

    always_comb begin
        head_new.fields.dst_mac   = i_ctrl_mac;
        head_new.fields.src_mac   = i_hcp_mac;
        head_new.fields.ethertype = TSMP_ETHERTYPE;
        head_new.fields.subtype   = TSMP_SUBTYPE;
        head_new.fields.tsmp_type = TSMP_TYPE;
    end

    ////////////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////////////
    logic [2:0]        state;
    logic [HCNT_W-1:0] hcnt;
    logic              rep_first;
    logic              start;

    assign start = i_data_wr && i_data[8];

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && start && !i_encapsulated_flag) begin
            head_q <= head_new;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state         <= ST_IDLE;
            hcnt          <= '0;
            rep_first     <= 1'b0;
            o_data        <= '0;
            o_data_wr     <= 1'b0;
            o_encap_done  <= 1'b0;
            o_decap_done  <= 1'b0;
            o_decap_short <= 1'b0;
        end else begin
            o_data_wr     <= 1'b0;
            o_encap_done  <= 1'b0;
            o_decap_done  <= 1'b0;
            o_decap_short <= 1'b0;
            case (state)
                ST_IDLE: begin
                    hcnt <= HCNT_W'(1);
                    if (start && !i_encapsulated_flag) begin
                        // first header byte leaves straight away
                        o_data    <= {1'b1, head_new.bytes[0]};
                        o_data_wr <= 1'b1;
                        state     <= ST_HEAD;
                    end else if (start) begin
                        state <= ST_DISCARD;
                    end
                end
                ST_HEAD: begin
                    o_data    <= {1'b0, head_q.bytes[hcnt]};
                    o_data_wr <= 1'b1;
                    hcnt      <= hcnt + 1'b1;
                    if (hcnt == HCNT_LAST) begin
                        rep_first <= 1'b1;
                        state     <= ST_REPLAY;
                    end
                end
                ST_REPLAY: begin
                    // first marker of the payload is dropped, last one kept
                    o_data    <= {dly_tap[8] && !rep_first, dly_tap[7:0]};
                    o_data_wr <= 1'b1;
                    rep_first <= 1'b0;
                    if (dly_tap[8] && !rep_first) begin
                        o_encap_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                ST_DISCARD: begin
                    hcnt <= hcnt + 1'b1;
                    if (start) begin
                        o_decap_short <= 1'b1;
                        state         <= ST_IDLE;
                    end else if (hcnt == HCNT_LAST) begin
                        state <= ST_DEC_FIRST;
                    end
                end
                ST_DEC_FIRST: begin
                    if (start) begin
                        // nothing after the header, drop the frame
                        o_decap_short <= 1'b1;
                        state         <= ST_IDLE;
                    end else begin
                        o_data    <= {1'b1, i_data[7:0]};
                        o_data_wr <= i_data_wr;
                        state     <= ST_PASS;
                    end
                end
                ST_PASS: begin
                    o_data    <= i_data;
                    o_data_wr <= i_data_wr;
                    if (start) begin
                        o_decap_done <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // last input word of an encap frame taken, replay still running
    logic enc_tail;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            enc_tail <= 1'b0;
        end else if (state inside {ST_HEAD, ST_REPLAY}) begin
            enc_tail <= enc_tail || start;
        end else begin
            enc_tail <= 1'b0;
        end
    end

    // header bytes go out back to back
    a_head_wr: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        state == ST_HEAD |-> o_data_wr);

    // a decap frame only begins once the replay has drained
    a_no_overlap: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        enc_tail |-> !i_data_wr);

endmodule

`default_nettype wire

// File: hw/tunnel_pkg.sv
// tunnel package
// TSMP header layout, protocol constants and register map of the
// control-frame tunnel
`default_nettype none

package tunnel_pkg;

    // bytes added on encapsulation, removed on decapsulation
    localparam int TSMP_HEAD_BYTES = 16;

    localparam logic [15:0] TSMP_ETHERTYPE = 16'hff01;
    localparam logic [7:0]  TSMP_SUBTYPE   = 8'h04;
    localparam logic [7:0]  TSMP_TYPE      = 8'h01;

    // one header word, seen as named fields or as bytes in wire order
    typedef union packed {
        struct packed {
            logic [47:0] dst_mac;
            logic [47:0] src_mac;
            logic [15:0] ethertype;
            logic [7:0]  subtype;
            logic [7:0]  tsmp_type;
        } fields;
        logic [0:TSMP_HEAD_BYTES-1][7:0] bytes;
    } tsmp_head_u;

    ////////////////////////////////////////////////////////////////////////////
    // register map
    ////////////////////////////////////////////////////////////////////////////
    localparam int REG_ADDR_W = 5;

    localparam logic [REG_ADDR_W-1:0] REG_CTRL_MAC_HI = 5'h00;
    localparam logic [REG_ADDR_W-1:0] REG_CTRL_MAC_LO = 5'h04;
    localparam logic [REG_ADDR_W-1:0] REG_HCP_MAC_HI  = 5'h08;
    localparam logic [REG_ADDR_W-1:0] REG_HCP_MAC_LO  = 5'h0c;
    localparam logic [REG_ADDR_W-1:0] REG_ENCAP_CNT   = 5'h10;
    localparam logic [REG_ADDR_W-1:0] REG_DECAP_CNT   = 5'h14;
    localparam logic [REG_ADDR_W-1:0] REG_SHORT_CNT   = 5'h18;

    localparam logic [1:0] RESP_OKAY = 2'b00;

endpackage

`default_nettype wire

// File: hw/tunnel_subsystem_top.sv
// tunnel subsystem top
// AXI4-Lite register block and the TSMP frame processor
`timescale 1ns/1ns
`default_nettype none

module tunnel_subsystem_top
    import tunnel_pkg::*;
#(
    parameter int CNT_W = 16
) (
    input  wire                   i_clk,
    input  wire                   i_rst_n,

    input  wire  [REG_ADDR_W-1:0] i_axil_awaddr,
    input  wire                   i_axil_awvalid,
    output logic                  o_axil_awready,
    input  wire  [31:0]           i_axil_wdata,
    input  wire  [3:0]            i_axil_wstrb,
    input  wire                   i_axil_wvalid,
    output logic                  o_axil_wready,
    output logic [1:0]            o_axil_bresp,
    output logic                  o_axil_bvalid,
    input  wire                   i_axil_bready,
    input  wire  [REG_ADDR_W-1:0] i_axil_araddr,
    input  wire                   i_axil_arvalid,
    output logic                  o_axil_arready,
    output logic [31:0]           o_axil_rdata,
    output logic [1:0]            o_axil_rresp,
    output logic                  o_axil_rvalid,
    input  wire                   i_axil_rready,

    input  wire  [8:0]            i_data,
    input  wire                   i_data_wr,
    input  wire                   i_encapsulated_flag,
    output logic [8:0]            o_data,
    output logic                  o_data_wr
);

    logic [47:0] ctrl_mac;
    logic [47:0] hcp_mac;
    logic        encap_done;
    logic        decap_done;
    logic        decap_short;

    tunnel_cfg_regs #(
        .CNT_W (CNT_W)
    ) tunnel_cfg_regs_inst (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_axil_awaddr  (i_axil_awaddr),
        .i_axil_awvalid (i_axil_awvalid),
        .o_axil_awready (o_axil_awready),
        .i_axil_wdata   (i_axil_wdata),
        .i_axil_wstrb   (i_axil_wstrb),
        .i_axil_wvalid  (i_axil_wvalid),
        .o_axil_wready  (o_axil_wready),
        .o_axil_bresp   (o_axil_bresp),
        .o_axil_bvalid  (o_axil_bvalid),
        .i_axil_bready  (i_axil_bready),
        .i_axil_araddr  (i_axil_araddr),
        .i_axil_arvalid (i_axil_arvalid),
        .o_axil_arready (o_axil_arready),
        .o_axil_rdata   (o_axil_rdata),
        .o_axil_rresp   (o_axil_rresp),
        .o_axil_rvalid  (o_axil_rvalid),
        .i_axil_rready  (i_axil_rready),
        .i_encap_done   (encap_done),
        .i_decap_done   (decap_done),
        .i_decap_short  (decap_short),
        .o_ctrl_mac     (ctrl_mac),
        .o_hcp_mac      (hcp_mac)
    );

    tunnel_frame_process tunnel_frame_process_inst (
        .i_clk               (i_clk),
        .i_rst_n             (i_rst_n),
        .i_ctrl_mac          (ctrl_mac),
        .i_hcp_mac           (hcp_mac),
        .i_data              (i_data),
        .i_data_wr           (i_data_wr),
        .i_encapsulated_flag (i_encapsulated_flag),
        .o_data              (o_data),
        .o_data_wr           (o_data_wr),
        .o_encap_done        (encap_done),
        .o_decap_done        (decap_done),
        .o_decap_short       (decap_short)
    );

endmodule

`default_nettype wire

// File: sim/tb_tunnel_subsystem.sv
// tunnel subsystem testbench
// drives AXI4-Lite register traffic and mixed encap/decap frames into the
// tunnel top level and checks every output word and its cycle
`timescale 1ns/1ns
`default_nettype none

module tb_tunnel_subsystem
    import tunnel_pkg::*;
();

    localparam int MAX_CYCLES = 4000;

    logic        clk;
    logic        rst_n;
    logic [4:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [4:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [8:0]  din;
    logic        din_wr;
    logic        encap_flag;
    logic [8:0]  dout;
    logic        dout_wr;

    // scoreboard state, refreshed on the falling edge
    logic [8:0]  exp_word_q[$];
    int          exp_cyc_q[$];
    logic [8:0]  exp_word;
    int          exp_cyc;
    logic        exp_avail;
    int          out_cyc;

    // register model: ctrl hi, ctrl lo, hcp hi, hcp lo
    logic [31:0] shadow [0:3];
    int          cycles;
    int          errors;
    int          encap_sent;
    int          decap_sent;
    int          short_sent;

    tunnel_subsystem_top #(
        .CNT_W (16)
    ) tunnel_subsystem_top_inst (
        .i_clk               (clk),
        .i_rst_n             (rst_n),
        .i_axil_awaddr       (awaddr),
        .i_axil_awvalid      (awvalid),
        .o_axil_awready      (awready),
        .i_axil_wdata        (wdata),
        .i_axil_wstrb        (wstrb),
        .i_axil_wvalid       (wvalid),
        .o_axil_wready       (wready),
        .o_axil_bresp        (bresp),
        .o_axil_bvalid       (bvalid),
        .i_axil_bready       (bready),
        .i_axil_araddr       (araddr),
        .i_axil_arvalid      (arvalid),
        .o_axil_arready      (arready),
        .o_axil_rdata        (rdata),
        .o_axil_rresp        (rresp),
        .o_axil_rvalid       (rvalid),
        .i_axil_rready       (rready),
        .i_data              (din),
        .i_data_wr           (din_wr),
        .i_encapsulated_flag (encap_flag),
        .o_data              (dout),
        .o_data_wr           (dout_wr)
    );

    always #4 clk = ~clk;

    // watchdog
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output checking
    ////////////////////////////////////////////////////////////////////////////
    always @(negedge clk) begin
        if (dout_wr) begin
            out_cyc = cycles;
            if (exp_word_q.size() > 0) begin
                exp_word  = exp_word_q.pop_front();
                exp_cyc   = exp_cyc_q.pop_front();
                exp_avail = 1'b1;
            end else begin
                exp_avail = 1'b0;
            end
        end
    end

    a_out_word: assert property (@(posedge clk) disable iff (!rst_n)
            dout_wr && exp_avail |-> dout == exp_word)
        else begin
            errors++;
            $display("FAIL t=%0t o_data: expected %h, got %h",
                     $time, exp_word, $sampled(dout));
        end

    a_out_time: assert property (@(posedge clk) disable iff (!rst_n)
            dout_wr && exp_avail |-> out_cyc == exp_cyc)
        else begin
            errors++;
            $display("FAIL t=%0t o_data_wr cycle: expected %0d, got %0d",
                     $time, exp_cyc, out_cyc);
        end

    a_out_unexpected: assert property (@(posedge clk) disable iff (!rst_n)
            dout_wr |-> exp_avail)
        else begin
            errors++;
            $display("t=%0t an output word arrived while none was expected", $time);
        end

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [7:0] head_byte(input int h);
        logic [127:0] hdr;
        hdr = {shadow[0][15:0], shadow[1], shadow[2][15:0], shadow[3],
               16'hff01, 8'h04, 8'h01};
        return hdr[127 - 8 * h -: 8];
    endfunction

    function automatic void push_expected(input logic [8:0] w, input int c);
        exp_word_q.push_back(w);
        exp_cyc_q.push_back(c);
    endfunction

    task automatic axil_write(input logic [4:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input bit split);
        bit aw_done;
        bit w_done;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= strb;
        wvalid  <= !split;
        while (!(aw_done && w_done)) begin
            @(posedge clk);
            if (awvalid && awready) begin
                aw_done = 1'b1;
                awvalid <= 1'b0;
            end
            if (wvalid && wready) begin
                w_done = 1'b1;
                wvalid <= 1'b0;
            end else if (aw_done && !w_done) begin
                // data follows the address on a later cycle
                wvalid <= 1'b1;
            end
        end
        bready <= 1'b1;
        do @(posedge clk); while (!bvalid);
        bready <= 1'b0;
        assert (bresp == 2'b00) else begin
            errors++;
            $display("FAIL t=%0t o_axil_bresp: expected %h, got %h", $time, 2'b00, bresp);
        end
        if (addr < REG_ENCAP_CNT) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) begin
                    shadow[addr[3:2]][8*b +: 8] = data[8*b +: 8];
                end
            end
            // HI registers keep only 16 bits
            if (!addr[2]) begin
                shadow[addr[3:2]][31:16] = 16'd0;
            end
        end
    endtask

    task automatic axil_read(input logic [4:0] addr, output logic [31:0] data);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        rready  <= 1'b1;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        assert (rresp == 2'b00) else begin
            errors++;
            $display("FAIL t=%0t o_axil_rresp: expected %h, got %h", $time, 2'b00, rresp);
        end
        rready <= 1'b0;
    endtask

    task automatic check_reg(input logic [4:0] addr, input string name,
                             input logic [31:0] exp);
        logic [31:0] val;
        axil_read(addr, val);
        assert (val == exp) else begin
            errors++;
            $display("FAIL t=%0t %s: expected %h, got %h", $time, name, exp, val);
        end
    endtask

    task automatic send_frame(input bit decap, input int len);
        logic [7:0] pay [0:63];
        int         base;
        for (int i = 0; i < len; i++) begin
            pay[i] = 8'($urandom);
        end
        @(posedge clk);
        base = cycles;
        if (!decap) begin
            for (int h = 0; h < 16; h++) begin
                push_expected({h == 0, head_byte(h)}, base + 2 + h);
            end
            for (int i = 0; i < len; i++) begin
                push_expected({i == len - 1, pay[i]}, base + 18 + i);
            end
            encap_sent++;
        end else if (len >= 18) begin
            for (int i = 16; i < len; i++) begin
                push_expected({i == 16 || i == len - 1, pay[i]}, base + 2 + i);
            end
            decap_sent++;
        end else begin
            short_sent++;
        end
        for (int i = 0; i < len; i++) begin
            if (i != 0) begin
                @(posedge clk);
            end
            din        <= {i == 0 || i == len - 1, pay[i]};
            din_wr     <= 1'b1;
            encap_flag <= decap;
        end
        @(posedge clk);
        din        <= '0;
        din_wr     <= 1'b0;
        encap_flag <= 1'b0;
        // encap needs the replay to drain before the next frame
        repeat (decap ? 2 : 20) @(posedge clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        void'($urandom(32'h8ff3_c8ac));
        clk        = 1'b0;
        rst_n      = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        din        = '0;
        din_wr     = 1'b0;
        encap_flag = 1'b0;
        exp_word   = '0;
        exp_cyc    = 0;
        exp_avail  = 1'b0;
        out_cyc    = 0;
        cycles     = 0;
        errors     = 0;
        encap_sent = 0;
        decap_sent = 0;
        short_sent = 0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        // everything reads zero out of reset
        check_reg(REG_CTRL_MAC_HI, "ctrl_mac_hi", 32'd0);
        check_reg(REG_CTRL_MAC_LO, "ctrl_mac_lo", 32'd0);
        check_reg(REG_HCP_MAC_HI, "hcp_mac_hi", 32'd0);
        check_reg(REG_HCP_MAC_LO, "hcp_mac_lo", 32'd0);
        check_reg(REG_ENCAP_CNT, "encap_cnt", 32'd0);
        check_reg(REG_DECAP_CNT, "decap_cnt", 32'd0);
        check_reg(REG_SHORT_CNT, "short_cnt", 32'd0);

        axil_write(REG_CTRL_MAC_HI, 32'h0000_0a1b, 4'hf, 1'b0);
        axil_write(REG_CTRL_MAC_LO, 32'h2c3d_4e5f, 4'hf, 1'b1);
        axil_write(REG_HCP_MAC_HI, 32'hffff_6071, 4'hf, 1'b0);
        axil_write(REG_HCP_MAC_LO, 32'h8293_a4b5, 4'hf, 1'b0);
        axil_write(REG_HCP_MAC_LO, 32'hdead_beef, 4'b0110, 1'b0);
        // read-only counter, write is ignored
        axil_write(REG_ENCAP_CNT, 32'h0000_1234, 4'hf, 1'b0);
        check_reg(REG_CTRL_MAC_HI, "ctrl_mac_hi", shadow[0]);
        check_reg(REG_CTRL_MAC_LO, "ctrl_mac_lo", shadow[1]);
        check_reg(REG_HCP_MAC_HI, "hcp_mac_hi", shadow[2]);
        check_reg(REG_HCP_MAC_LO, "hcp_mac_lo", shadow[3]);

        // mixed traffic, one of each kind in turn
        for (int n = 0; n < 15; n++) begin
            case (n % 3)
                0:       send_frame(1'b0, $urandom_range(40, 2));
                1:       send_frame(1'b1, $urandom_range(40, 18));
                default: send_frame(1'b1, $urandom_range(17, 2));
            endcase
        end
        repeat (4) @(posedge clk);

        check_reg(REG_ENCAP_CNT, "encap_cnt", encap_sent);
        check_reg(REG_DECAP_CNT, "decap_cnt", decap_sent);
        check_reg(REG_SHORT_CNT, "short_cnt", short_sent);
        assert (exp_word_q.size() == 0) else begin
            errors++;
            $display("%0d expected output words never arrived", exp_word_q.size());
        end

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tunnel_subsystem_top.f
hw/tunnel_pkg.sv
hw/tunnel_cfg_regs.sv
hw/tunnel_frame_process.sv
hw/tunnel_subsystem_top.sv
sim/tb_tunnel_subsystem.sv
